// ==== hdl/io_pkg.sv ====
package io_pkg;

    // ****************************************
    // Data widths.
    // ****************************************

    localparam int data_width = 32;    // Address, write data and read data.
    localparam int byte_width = 8;     // UART character.

    // ****************************************
    // Memory-mapped register addresses.
    // ****************************************

    localparam logic [data_width-1:0] addr_uart_ctrl   = 32'h8000_0000; // Status, read.
    localparam logic [data_width-1:0] addr_uart_rdata  = 32'h8000_0004; // Rx byte, read.
    localparam logic [data_width-1:0] addr_uart_tdata  = 32'h8000_0008; // Tx byte, write.
    localparam logic [data_width-1:0] addr_cycle_cnt   = 32'h8000_0010;
    localparam logic [data_width-1:0] addr_inst_cnt    = 32'h8000_0014;
    localparam logic [data_width-1:0] addr_rst_cnt     = 32'h8000_0018; // Clear counters.
    localparam logic [data_width-1:0] addr_br_inst_cnt = 32'h8000_001C;
    localparam logic [data_width-1:0] addr_br_suc_cnt  = 32'h8000_0020;

    // ****************************************
    // One-hot access strobe positions.
    // ****************************************

    localparam int sel_count = 8;

    localparam int sel_ctrl    = 0;
    localparam int sel_rdata   = 1;
    localparam int sel_tdata   = 2;
    localparam int sel_cycle   = 3;
    localparam int sel_inst    = 4;
    localparam int sel_rst     = 5;
    localparam int sel_br_inst = 6;
    localparam int sel_br_suc  = 7;

endpackage

// ==== hdl/mmio_decode.sv ====
`timescale 1ns/10ps

module mmio_decode (
    input  logic [io_pkg::data_width-1:0] addr,
    input  logic                          io_en,
    output logic [io_pkg::sel_count-1:0]  sel
);

    // Full 32-bit compare, so aliases of a register never hit.
    always_comb begin
        sel = '0;
        if (io_en) begin
            case (addr)
                io_pkg::addr_uart_ctrl: begin
                    sel[io_pkg::sel_ctrl] = 1'b1;
                end
                io_pkg::addr_uart_rdata: begin
                    sel[io_pkg::sel_rdata] = 1'b1;
                end
                io_pkg::addr_uart_tdata: begin
                    sel[io_pkg::sel_tdata] = 1'b1;
                end
                io_pkg::addr_cycle_cnt: begin
                    sel[io_pkg::sel_cycle] = 1'b1;
                end
                io_pkg::addr_inst_cnt: begin
                    sel[io_pkg::sel_inst] = 1'b1;
                end
                io_pkg::addr_rst_cnt: begin
                    sel[io_pkg::sel_rst] = 1'b1;
                end
                io_pkg::addr_br_inst_cnt: begin
                    sel[io_pkg::sel_br_inst] = 1'b1;
                end
                io_pkg::addr_br_suc_cnt: begin
                    sel[io_pkg::sel_br_suc] = 1'b1;
                end
                default: begin
                    sel = '0;    // Unmapped address, no side effect.
                end
            endcase
        end
    end

endmodule

// ==== hdl/perf_counters.sv ====
`timescale 1ns/10ps

module perf_counters (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          clear,
    input  logic                          inst_ret,
    input  logic                          br_inst,
    input  logic                          br_suc,
    output logic [io_pkg::data_width-1:0] cycle_cnt,
    output logic [io_pkg::data_width-1:0] inst_cnt,
    output logic [io_pkg::data_width-1:0] br_inst_cnt,
    output logic [io_pkg::data_width-1:0] br_suc_cnt
);

    localparam logic [io_pkg::data_width-1:0] cnt_one = 1;

    // ****************************************
    // Counters.
    // ****************************************

    // Clear has priority over any increment on the same edge.
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            cycle_cnt   <= '0;
            inst_cnt    <= '0;
            br_inst_cnt <= '0;
            br_suc_cnt  <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + cnt_one;    // Free running.

            if (inst_ret) begin
                inst_cnt <= inst_cnt + cnt_one;
            end

            if (br_inst) begin
                br_inst_cnt <= br_inst_cnt + cnt_one;
            end

            // Correct predictions, counted independently of br_inst.
            if (br_suc) begin
                br_suc_cnt <= br_suc_cnt + cnt_one;
            end
        end
    end

endmodule

// ==== hdl/uart_tx.sv ====
`timescale 1ns/10ps

module uart_tx #(
    parameter int clock_freq = 125000000,
    parameter int baud_rate  = 115200
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [io_pkg::byte_width-1:0] tx_data,
    input  logic                          tx_valid,
    output logic                          tx_ready,
    output logic                          serial_out
);

    localparam int clocks_per_bit = clock_freq / baud_rate;
    localparam int cnt_width      = (clocks_per_bit > 1) ? $clog2(clocks_per_bit) : 1;
    localparam int frame_width    = io_pkg::byte_width + 2;    // Start, data, stop.

    localparam logic [cnt_width-1:0] cnt_last = cnt_width'(clocks_per_bit - 1);
    localparam logic [3:0]           bit_last = 4'(frame_width - 1);

    logic                   busy;
    logic [frame_width-1:0] frame;      // Shifts out LSB first.
    logic [cnt_width-1:0]   clk_cnt;    // Clocks within the current bit.
    logic [3:0]             bit_cnt;    // Bit within the frame.

    assign tx_ready   = ~busy;
    assign serial_out = frame[0];      // All ones while idle, so the line rests high.

    // ****************************************
    // Frame shifter.
    // ****************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            frame   <= '1;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (!busy) begin
            if (tx_valid) begin    // Handshake, ready is implied by idle.
                frame   <= {1'b1, tx_data, 1'b0};
                busy    <= 1'b1;
                clk_cnt <= '0;
                bit_cnt <= '0;
            end
        end else if (clk_cnt == cnt_last) begin
            clk_cnt <= '0;
            frame   <= {1'b1, frame[frame_width-1:1]};    // Back-fill with idle level.
            if (bit_cnt == bit_last) begin
                busy <= 1'b0;    // Stop bit fully sent.
            end else begin
                bit_cnt <= bit_cnt + 4'd1;
            end
        end else begin
            clk_cnt <= clk_cnt + cnt_width'(1);
        end
    end

endmodule

// ==== hdl/uart_rx.sv ====
`timescale 1ns/10ps

module uart_rx #(
    parameter int clock_freq = 125000000,
    parameter int baud_rate  = 115200
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          serial_in,
    output logic [io_pkg::byte_width-1:0] rx_data,
    output logic                          rx_valid,
    input  logic                          rx_ready
);

    localparam int clocks_per_bit = clock_freq / baud_rate;
    localparam int cnt_width      = (clocks_per_bit > 1) ? $clog2(clocks_per_bit) : 1;

    localparam logic [cnt_width-1:0] cnt_last = cnt_width'(clocks_per_bit - 1);
    localparam logic [cnt_width-1:0] cnt_half = cnt_width'(clocks_per_bit / 2);
    localparam logic [3:0]           bit_last = 4'(io_pkg::byte_width - 1);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } state_t;

    state_t                        state;
    logic [1:0]                    sync;       // Two-flop synchronizer.
    logic                          line_prev;
    logic                          line;
    logic                          fall;
    logic [cnt_width-1:0]          clk_cnt;
    logic [3:0]                    bit_cnt;
    logic [io_pkg::byte_width-1:0] shift;

    assign line = sync[1];
    assign fall = line_prev & ~line;

    always_ff @(posedge clk) begin
        if (rst) begin
            sync      <= 2'b11;    // Idle line level.
            line_prev <= 1'b1;
        end else begin
            sync      <= {sync[0], serial_in};
            line_prev <= line;
        end
    end

    // ****************************************
    // Receive FSM.
    // ****************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_idle;
            clk_cnt  <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            if (rx_ready) begin
                rx_valid <= 1'b0;    // Byte consumed.
            end
            case (state)
                st_idle: begin
                    clk_cnt <= '0;
                    if (fall) state <= st_start;
                end
                st_start: begin
                    if (clk_cnt == cnt_half) begin
                        clk_cnt <= '0;
                        bit_cnt <= '0;
                        state   <= line ? st_idle : st_data;    // Glitch rejection.
                    end else begin
                        clk_cnt <= clk_cnt + cnt_width'(1);
                    end
                end
                st_data: begin
                    if (clk_cnt == cnt_last) begin
                        clk_cnt <= '0;
                        shift   <= {line, shift[io_pkg::byte_width-1:1]};    // LSB first.
                        if (bit_cnt == bit_last) state <= st_stop;
                        else bit_cnt <= bit_cnt + 4'd1;
                    end else begin
                        clk_cnt <= clk_cnt + cnt_width'(1);
                    end
                end
                st_stop: begin
                    // Middle of the stop bit; a held byte is overwritten.
                    if (clk_cnt == cnt_last) begin
                        rx_data  <= shift;
                        rx_valid <= 1'b1;
                        state    <= st_idle;
                    end else begin
                        clk_cnt <= clk_cnt + cnt_width'(1);
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

// ==== hdl/mmio_readback.sv ====
`timescale 1ns/10ps

module mmio_readback (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [io_pkg::sel_count-1:0]  sel,
    input  logic                          tx_ready,
    input  logic                          rx_valid,
    input  logic [io_pkg::byte_width-1:0] rx_data,
    input  logic [io_pkg::data_width-1:0] cycle_cnt,
    input  logic [io_pkg::data_width-1:0] inst_cnt,
    input  logic [io_pkg::data_width-1:0] br_inst_cnt,
    input  logic [io_pkg::data_width-1:0] br_suc_cnt,
    output logic [io_pkg::data_width-1:0] dout
);

    logic [io_pkg::data_width-1:0] status;
    logic [io_pkg::data_width-1:0] rdata;
    logic [io_pkg::data_width-1:0] rd_value;

    assign status = {{(io_pkg::data_width-2){1'b0}}, rx_valid, tx_ready};
    assign rdata  = {{(io_pkg::data_width-io_pkg::byte_width){1'b0}}, rx_data};

    // Write strobes fall through to zero.
    always_comb begin
        rd_value = '0;
        if (sel[io_pkg::sel_ctrl])    rd_value = status;
        if (sel[io_pkg::sel_rdata])   rd_value = rdata;
        if (sel[io_pkg::sel_cycle])   rd_value = cycle_cnt;
        if (sel[io_pkg::sel_inst])    rd_value = inst_cnt;
        if (sel[io_pkg::sel_br_inst]) rd_value = br_inst_cnt;
        if (sel[io_pkg::sel_br_suc])  rd_value = br_suc_cnt;
    end

    // One cycle read latency.
    always_ff @(posedge clk) begin
        if (rst) begin
            dout <= '0;
        end else begin
            dout <= rd_value;
        end
    end

endmodule

// ==== hdl/io_top.sv ====
`timescale 1ns/10ps

module io_top #(
    parameter int clock_freq = 125000000,
    parameter int baud_rate  = 115200
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [io_pkg::data_width-1:0] addr,
    input  logic [io_pkg::data_width-1:0] din,
    input  logic                          io_en,
    input  logic                          inst_ret,
    input  logic                          br_inst,
    input  logic                          br_suc,
    input  logic                          serial_in,
    output logic                          serial_out,
    output logic [io_pkg::data_width-1:0] dout
);

    logic [io_pkg::sel_count-1:0]  sel;
    logic                          tx_ready;
    logic [io_pkg::byte_width-1:0] rx_data;
    logic                          rx_valid;
    logic [io_pkg::data_width-1:0] cycle_cnt;
    logic [io_pkg::data_width-1:0] inst_cnt;
    logic [io_pkg::data_width-1:0] br_inst_cnt;
    logic [io_pkg::data_width-1:0] br_suc_cnt;

    // ****************************************
    // Decode.
    // ****************************************

    mmio_decode mmio_decode_i (
        .addr  (addr),
        .io_en (io_en),
        .sel   (sel)
    );

    // ****************************************
    // Execute.
    // ****************************************

    uart_tx #(
        .clock_freq (clock_freq),
        .baud_rate  (baud_rate)
    ) uart_tx_i (
        .clk        (clk),
        .rst        (rst),
        .tx_data    (din[io_pkg::byte_width-1:0]),    // Low byte only.
        .tx_valid   (sel[io_pkg::sel_tdata]),
        .tx_ready   (tx_ready),
        .serial_out (serial_out)
    );

    uart_rx #(
        .clock_freq (clock_freq),
        .baud_rate  (baud_rate)
    ) uart_rx_i (
        .clk       (clk),
        .rst       (rst),
        .serial_in (serial_in),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .rx_ready  (sel[io_pkg::sel_rdata])    // Reading RDATA consumes the byte.
    );

    perf_counters perf_counters_i (
        .clk         (clk),
        .rst         (rst),
        .clear       (sel[io_pkg::sel_rst]),
        .inst_ret    (inst_ret),
        .br_inst     (br_inst),
        .br_suc      (br_suc),
        .cycle_cnt   (cycle_cnt),
        .inst_cnt    (inst_cnt),
        .br_inst_cnt (br_inst_cnt),
        .br_suc_cnt  (br_suc_cnt)
    );

    // Result.
    mmio_readback mmio_readback_i (
        .clk         (clk),
        .rst         (rst),
        .sel         (sel),
        .tx_ready    (tx_ready),
        .rx_valid    (rx_valid),
        .rx_data     (rx_data),
        .cycle_cnt   (cycle_cnt),
        .inst_cnt    (inst_cnt),
        .br_inst_cnt (br_inst_cnt),
        .br_suc_cnt  (br_suc_cnt),
        .dout        (dout)
    );

endmodule

// ==== sim/io_top_tb.sv ====
`timescale 1ns/10ps

module io_top_tb;

    localparam int clock_freq     = 1000000;
    localparam int baud_rate      = 100000;
    localparam int clocks_per_bit = clock_freq / baud_rate;
    localparam int frame_cycles   = 10 * clocks_per_bit;    // Start, eight data, stop.
    localparam int poll_limit     = 200;
    localparam int rx_empty       = 0;
    localparam int rx_flight      = 1;
    localparam int rx_held        = 2;

    logic                          clk = 1'b0;
    logic                          rst;
    logic [io_pkg::data_width-1:0] addr;
    logic [io_pkg::data_width-1:0] din;
    logic                          io_en;
    logic                          inst_ret;
    logic                          br_inst;
    logic                          br_suc;
    logic                          serial_out;
    logic [io_pkg::data_width-1:0] dout;

    // Model state is updated on every rising edge.
    logic [31:0] m_cycle;
    logic [31:0] m_inst;
    logic [31:0] m_br_inst;
    logic [31:0] m_br_suc;
    int          m_busy = 0;    // Clocks left in the tx frame.
    logic [9:0]  m_frame = '1;
    logic [7:0]  m_rx_byte;
    int          m_rx_state = rx_empty;
    logic [31:0] exp_dout = '0;
    logic [31:0] exp_mask = '1;

    logic [31:0] rng_state;
    int          err_count = 0;
    int          check_count = 0;
    int          timeouts = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          fail_start = 0;
    string       test_name;

    always #50 clk = ~clk;

    io_top #(
        .clock_freq (clock_freq),
        .baud_rate  (baud_rate)
    ) io_top_i (
        .clk        (clk),
        .rst        (rst),
        .addr       (addr),
        .din        (din),
        .io_en      (io_en),
        .inst_ret   (inst_ret),
        .br_inst    (br_inst),
        .br_suc     (br_suc),
        .serial_in  (serial_out),    // Loopback.
        .serial_out (serial_out),
        .dout       (dout)
    );

    // ****************************************
    // Reference model.
    // ****************************************

    function automatic logic [31:0] ref_read(input logic [31:0] a);
        logic [31:0] v;
        v = '0;
        case (a)
            io_pkg::addr_uart_ctrl:   v = {30'd0, m_rx_state == rx_held, m_busy == 0};
            io_pkg::addr_uart_rdata:  v = {24'd0, m_rx_byte};
            io_pkg::addr_cycle_cnt:   v = m_cycle;
            io_pkg::addr_inst_cnt:    v = m_inst;
            io_pkg::addr_br_inst_cnt: v = m_br_inst;
            io_pkg::addr_br_suc_cnt:  v = m_br_suc;
            default:                  v = '0;    // Write and unused addresses.
        endcase
        return v;
    endfunction

    // Line level from the position inside the frame.
    function automatic logic ref_serial();
        logic [9:0] sh;
        if (m_busy == 0) return 1'b1;
        sh = m_frame >> ((frame_cycles - m_busy) / clocks_per_bit);
        return sh[0];
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            m_cycle    = '0;
            m_inst     = '0;
            m_br_inst  = '0;
            m_br_suc   = '0;
            m_busy     = 0;
            m_frame    = '1;
            m_rx_state = rx_empty;
            exp_dout   = '0;
            exp_mask   = '1;
        end else begin
            exp_dout = io_en ? ref_read(addr) : '0;    // Values before this edge.
            exp_mask = '1;
            if (io_en && addr == io_pkg::addr_uart_ctrl && m_rx_state == rx_flight)
                exp_mask = 32'hFFFF_FFFD;    // rx_valid timing inside the frame is loose.
            if (io_en && addr == io_pkg::addr_rst_cnt) begin
                m_cycle   = '0;
                m_inst    = '0;
                m_br_inst = '0;
                m_br_suc  = '0;
            end else begin
                m_cycle = m_cycle + 32'd1;
                if (inst_ret) m_inst = m_inst + 32'd1;
                if (br_inst) m_br_inst = m_br_inst + 32'd1;
                if (br_suc) m_br_suc = m_br_suc + 32'd1;
            end
            if (io_en && addr == io_pkg::addr_uart_rdata && m_rx_state == rx_held)
                m_rx_state = rx_empty;
            if (m_busy != 0) begin
                m_busy = m_busy - 1;
                if (m_busy == 0) begin    // Looped-back byte lands by the stop bit.
                    m_rx_state = rx_held;
                    m_rx_byte  = m_frame[8:1];
                end
            end else if (io_en && addr == io_pkg::addr_uart_tdata) begin
                m_busy     = frame_cycles;
                m_frame    = {1'b1, din[7:0], 1'b0};
                m_rx_state = rx_flight;
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        check_count++;
        if (exp !== act) begin
            err_count++;
            $display("mismatch at %0t: %s expected %h, actual %h", $time, name, exp, act);
        end
    endtask

    // Outputs are stable at the falling edge.
    always @(negedge clk) begin
        check_value("dout", exp_dout & exp_mask, dout & exp_mask);
        check_value("serial_out", {31'd0, ref_serial()}, {31'd0, serial_out});
    end

    // ****************************************
    // Stimulus helpers.
    // ****************************************

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic drive_bus(input logic [31:0] a, input logic [31:0] d, input logic en);
        @(posedge clk);
        addr  <= a;
        din   <= d;
        io_en <= en;
    endtask

    // One access and a look at dout in the following cycle.
    task automatic access_reg(input logic [31:0] a, input logic [31:0] d,
                              output logic [31:0] rd);
        drive_bus(a, d, 1'b1);
        drive_bus('0, '0, 1'b0);
        @(negedge clk);
        rd = dout;
    endtask

    task automatic run_events(input int n);
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            r = next_rand();
            inst_ret <= r[0];
            br_inst  <= r[1];
            br_suc   <= r[1] & r[2];    // A correct prediction needs a branch.
        end
        @(posedge clk);
        inst_ret <= 1'b0;
        br_inst  <= 1'b0;
        br_suc   <= 1'b0;
    endtask

    task automatic poll_rx_ready();
        logic [31:0] rd;
        int          tries;
        rd    = '0;
        tries = 0;
        while (rd[1:0] != 2'b11 && tries < poll_limit) begin
            access_reg(io_pkg::addr_uart_ctrl, '0, rd);
            tries++;
        end
        if (rd[1:0] != 2'b11) begin
            timeouts++;
            $display("timeout at %0t: no received byte after %0d status reads", $time, tries);
        end
    endtask

    task automatic begin_test(input string name);
        test_name  = name;
        fail_start = err_count + timeouts;
    endtask

    task automatic end_test();
        int n;
        n = err_count + timeouts - fail_start;
        tests_run++;
        if (n == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", test_name, n);
        end
    endtask

    task automatic read_counters();
        logic [31:0] rd;
        access_reg(io_pkg::addr_cycle_cnt, '0, rd);
        access_reg(io_pkg::addr_inst_cnt, '0, rd);
        access_reg(io_pkg::addr_br_inst_cnt, '0, rd);
        access_reg(io_pkg::addr_br_suc_cnt, '0, rd);
    endtask

    // ****************************************
    // Test sequence.
    // ****************************************

    initial begin
        logic [31:0] rd;
        logic [7:0]  b;
        rng_state = 32'd5500;
        rst      <= 1'b1;
        addr     <= '0;
        din      <= '0;
        io_en    <= 1'b0;
        inst_ret <= 1'b0;
        br_inst  <= 1'b0;
        br_suc   <= 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        begin_test("reset");
        access_reg(io_pkg::addr_uart_ctrl, '0, rd);
        read_counters();
        repeat (3) @(posedge clk);    // dout must stay zero in idle cycles.
        end_test();

        begin_test("counters");
        for (int round = 0; round < 4; round++) begin
            access_reg(io_pkg::addr_rst_cnt, next_rand(), rd);
            run_events(10 + int'(next_rand() % 32'd50));
            read_counters();
        end
        end_test();

        begin_test("uart loopback");
        for (int i = 0; i < 16; i++) begin
            b = 8'(next_rand() >> 8);
            access_reg(io_pkg::addr_uart_tdata, {24'd0, b}, rd);
            access_reg(io_pkg::addr_uart_ctrl, '0, rd);    // Busy now.
            poll_rx_ready();
            access_reg(io_pkg::addr_uart_rdata, '0, rd);
            access_reg(io_pkg::addr_uart_ctrl, '0, rd);    // Byte consumed.
        end
        end_test();

        begin_test("dropped write");
        drive_bus(io_pkg::addr_uart_tdata, {24'd0, 8'hA5}, 1'b1);
        drive_bus(io_pkg::addr_uart_tdata, {24'd0, 8'h3C}, 1'b1);
        drive_bus('0, '0, 1'b0);
        poll_rx_ready();
        access_reg(io_pkg::addr_uart_rdata, '0, rd);
        repeat (frame_cycles + 20) @(posedge clk);
        access_reg(io_pkg::addr_uart_ctrl, '0, rd);
        end_test();

        begin_test("unmapped");
        access_reg(io_pkg::addr_uart_tdata, {24'd0, 8'h5A}, rd);
        poll_rx_ready();
        access_reg(32'h8000_000C, next_rand(), rd);
        access_reg(32'h8000_0024, next_rand(), rd);
        access_reg(32'h0000_0000, next_rand(), rd);
        access_reg(32'h8000_0011, next_rand(), rd);
        access_reg(io_pkg::addr_uart_ctrl, '0, rd);    // Byte still held.
        access_reg(io_pkg::addr_uart_rdata, '0, rd);
        read_counters();
        access_reg(io_pkg::addr_rst_cnt, '0, rd);
        read_counters();
        end_test();

        $display("tests %0d, failed %0d, checks %0d, mismatches %0d, timeouts %0d",
                 tests_run, tests_failed, check_count, err_count, timeouts);
        if (err_count == 0 && timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
hdl/io_pkg.sv
hdl/mmio_decode.sv
hdl/perf_counters.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/mmio_readback.sv
hdl/io_top.sv
sim/io_top_tb.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check $(LOG)"
	@echo "make clean  remove the build folder and the log"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --timescale 1ns/10ps -f vlog.f \
		--top-module io_top_tb --Mdir obj_dir -o io_top_tb
	./obj_dir/io_top_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
